// File: memCtrl.f
hw/memCtrlPkg.sv
hw/slotTableIf.sv
hw/streamFifo.sv
hw/transferTable.sv
hw/readRequester.sv
hw/readDataRouter.sv
hw/memCtrlTop.sv
tests/memCtrlTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= memCtrlTb
FILELIST ?= memCtrl.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJDIR)

// File: tests/memCtrlTb.sv
module memCtrlTb import memCtrlPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int numReqs = 300;
    localparam int acceptTimeout = 40000;
    localparam int drainTimeout = 5000;

    typedef struct packed {
        logic isFill;
        logic [addrW-1:0] addr;
        logic [cacheAddrW-1:0] tag;
    } reqRec;

    typedef struct packed {
        reqRec req;
        logic [slotIdW-1:0] id;
        logic [axiLenW-1:0] len;
        logic [axiSizeW-1:0] size;
        logic [axiBurstW-1:0] burst;
    } arRec;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [numClients-1:0] reqValid = '0;
    memCmd reqCmd [numClients] = '{cmdNone, cmdNone};
    logic [addrW-1:0] reqAddr [numClients] = '{'0, '0};
    logic [cacheAddrW-1:0] reqTag [numClients] = '{'0, '0};
    logic [numClients-1:0] stall;
    logic [slotIdW-1:0] arId;
    logic [addrW-1:0] arAddr;
    logic [axiLenW-1:0] arLen;
    logic [axiSizeW-1:0] arSize;
    logic [axiBurstW-1:0] arBurst;
    logic arValid;
    logic arReady = 1'b0;
    logic [slotIdW-1:0] rId = '0;
    logic [dataW-1:0] rData = '0;
    logic rLast = 1'b0;
    logic rValid = 1'b0;
    logic rReady;
    logic cacheWe;
    logic [cacheAddrW-1:0] cacheAddr;
    logic [dataW-1:0] cacheData;
    logic loadValid;
    logic [cacheAddrW-1:0] loadTag;
    logic [loadW-1:0] loadData;
    logic fillDone;
    logic [cacheAddrW-1:0] fillTag;

    // Testbench model state
    reqRec held [numClients];
    reqRec waitAr [$];
    arRec arQ [$];
    reqRec doneQ [$];
    logic [dataW-1:0] cache [2**cacheAddrW];
    int lineCnt [2**(cacheAddrW-beatIdxW)] = '{default: 0};
    int issued = 0;
    int accepted = 0;
    int retired = 0;
    int beat = 0;
    int arHold = 0;
    logic seeded = 1'b0;

    memCtrlTop uut (.*);

    always #50 clk = ~clk;

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // Memory content of one beat from its byte address
    function automatic logic [dataW-1:0] modelBeat(input logic [addrW-1:0] a);
        return {~a, a * 32'd3, {a[15:0], a[31:16]}, a ^ 32'h5a5a_a5a5};
    endfunction

    function automatic logic arFits(input reqRec r);
        if (r.isFill) begin
            return arAddr == r.addr && arLen == axiLenW'(beatsPerLine - 1) &&
                arSize == sizeBeat && arBurst == burstIncr;
        end
        return arAddr == r.addr && arLen == '0 && arSize == sizeWord && arBurst == burstFixed;
    endfunction

    // Lowest requesting client wins unless its fill line is busy or no slot is free
    function automatic logic [numClients-1:0] expectStall();
        logic [numClients-1:0] s;
        logic won;
        s = '1;
        won = 1'b0;
        for (int c = 0; c < numClients; c++) begin
            if (!won && accepted - retired < numSlots && reqValid[c] &&
                !(reqCmd[c] == cmdFill && lineCnt[reqTag[c][cacheAddrW-1:beatIdxW]] != 0)) begin
                s[c] = 1'b0;
                won = 1'b1;
            end
        end
        return s;
    endfunction

    always @(posedge clk) begin
        reqRec done;
        arRec cur;
        logic [dataW-1:0] beatVal;
        logic [addrW-1:0] beatAddr;
        logic [cacheAddrW-1:0] idx;
        logic [numClients-1:0] expStall;
        logic [31:0] rnd;
        int foundIdx;
        if (!seeded) begin
            void'($urandom(32'hf0f));
            seeded = 1'b1;
        end
        if (!rst) begin
            if (cacheWe) begin
                cache[cacheAddr] = cacheData;
            end
            if (loadValid || fillDone) begin
                assert (doneQ.size() > 0)
                    else stopWithError("completion strobe with no finished read burst");
                done = doneQ.pop_front();
                retired++;
                if (loadValid) begin
                    assert (!done.isFill) else stopWithError("load result where a fill was due");
                    beatVal = modelBeat(done.addr);
                    assert (loadTag == done.tag) else stopWithError($sformatf(
                        "FAILED loadTag expected %h actual %h", done.tag, loadTag));
                    assert (loadData == beatVal[loadW-1:0]) else stopWithError($sformatf(
                        "FAILED loadData expected %h actual %h", beatVal[loadW-1:0], loadData));
                end else begin
                    assert (done.isFill) else stopWithError("fillDone where a load was due");
                    assert (fillTag == done.tag) else stopWithError($sformatf(
                        "FAILED fillTag expected %h actual %h", done.tag, fillTag));
                    for (int i = 0; i < beatsPerLine; i++) begin
                        idx = done.tag + cacheAddrW'(i);
                        beatVal = modelBeat(done.addr + addrW'(i * 16));
                        assert (cache[idx] == beatVal) else stopWithError($sformatf(
                            "FAILED cacheData expected %h actual %h", beatVal, cache[idx]));
                        // Stale data must not satisfy a later fill of this line
                        cache[idx] = 'x;
                    end
                    lineCnt[done.tag[cacheAddrW-1:beatIdxW]]--;
                end
            end
            expStall = expectStall();
            assert (stall == expStall) else stopWithError($sformatf(
                "FAILED stall expected %h actual %h", expStall, stall));

            // Clients
            for (int c = 0; c < numClients; c++) begin
                if (reqValid[c] && !stall[c]) begin
                    accepted++;
                    waitAr.push_back(held[c]);
                    if (held[c].isFill) begin
                        lineCnt[held[c].tag[cacheAddrW-1:beatIdxW]]++;
                    end
                    reqValid[c] <= 1'b0;
                    reqCmd[c] <= cmdNone;
                end else if (!reqValid[c] && issued < numReqs && ($urandom % 3) == 0) begin
                    rnd = $urandom;
                    issued++;
                    held[c].isFill = rnd[0];
                    if (rnd[0]) begin
                        // Few lines and tags so fills collide
                        reqAddr[c] <= 32'h1000_0000 | {23'd0, rnd[3:1], rnd[9:4]};
                        reqTag[c] <= {4'd0, rnd[11:10], rnd[13:12]};
                        reqCmd[c] <= cmdFill;
                        held[c].addr = 32'h1000_0000 | {23'd0, rnd[3:1], 6'd0};
                        held[c].tag = {4'd0, rnd[11:10], 2'd0};
                    end else begin
                        reqAddr[c] <= 32'h2000_0000 | {22'd0, rnd[8:1], 2'd0};
                        reqTag[c] <= rnd[16:9];
                        reqCmd[c] <= cmdLoadWord;
                        held[c].addr = 32'h2000_0000 | {22'd0, rnd[8:1], 2'd0};
                        held[c].tag = rnd[16:9];
                    end
                    reqValid[c] <= 1'b1;
                end
            end

            // AXI slave read address side
            if (arValid && arReady) begin
                foundIdx = -1;
                for (int i = 0; i < waitAr.size(); i++) begin
                    if (foundIdx < 0 && arFits(waitAr[i])) begin
                        foundIdx = i;
                    end
                end
                assert (foundIdx >= 0) else stopWithError($sformatf(
                    "AR addr %h len %h size %h burst %h matches no accepted request",
                    arAddr, arLen, arSize, arBurst));
                for (int i = 0; i < arQ.size(); i++) begin
                    assert (arQ[i].id != arId)
                        else stopWithError("AR id still in use by an outstanding read burst");
                end
                cur.req = waitAr[foundIdx];
                cur.id = arId;
                cur.len = arLen;
                cur.size = arSize;
                cur.burst = arBurst;
                arQ.push_back(cur);
                waitAr.delete(foundIdx);
            end
            if (arHold > 0) begin
                arHold--;
                arReady <= 1'b0;
            end else if (($urandom % 50) == 0) begin
                arHold = 20 + $urandom % 40;
                arReady <= 1'b0;
            end else begin
                arReady <= ($urandom % 4) != 0;
            end

            // AXI slave read data side with bursts in issue order
            if (rValid && rReady) begin
                if (rLast) begin
                    doneQ.push_back(arQ[0].req);
                    void'(arQ.pop_front());
                    beat = 0;
                end else begin
                    beat++;
                end
            end
            if (!(rValid && !rReady)) begin
                if (arQ.size() > 0 && ($urandom % 4) != 0) begin
                    cur = arQ[0];
                    beatAddr = (cur.burst == burstIncr) ?
                        cur.req.addr + (addrW'(beat) << cur.size) : cur.req.addr;
                    rValid <= 1'b1;
                    rId <= cur.id;
                    rData <= modelBeat(beatAddr);
                    rLast <= axiLenW'(beat) == cur.len;
                end else begin
                    rValid <= 1'b0;
                end
            end
        end
    end

    initial begin
        int waitCnt;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        waitCnt = 0;
        while (accepted < numReqs) begin
            @(posedge clk);
            waitCnt++;
            assert (waitCnt < acceptTimeout)
                else stopWithError("timeout while waiting for all requests to be accepted");
        end
        waitCnt = 0;
        while (retired < accepted) begin
            @(posedge clk);
            waitCnt++;
            assert (waitCnt < drainTimeout)
                else stopWithError("timeout while waiting for accepted requests to complete");
        end
        repeat (5) @(posedge clk);
        if (waitAr.size() == 0 && arQ.size() == 0 && doneQ.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stopWithError("requests left over after all completions");
        end
    end

endmodule

// File: hw/memCtrlTop.sv
module memCtrlTop import memCtrlPkg::*; (
    input logic clk,
    input logic rst,

    input logic [numClients-1:0] reqValid,
    input memCmd reqCmd [numClients],
    input logic [addrW-1:0] reqAddr [numClients],
    input logic [cacheAddrW-1:0] reqTag [numClients],
    output logic [numClients-1:0] stall,

    output logic [slotIdW-1:0] arId,
    output logic [addrW-1:0] arAddr,
    output logic [axiLenW-1:0] arLen,
    output logic [axiSizeW-1:0] arSize,
    output logic [axiBurstW-1:0] arBurst,
    output logic arValid,
    input logic arReady,

    input logic [slotIdW-1:0] rId,
    input logic [dataW-1:0] rData,
    input logic rLast,
    input logic rValid,
    output logic rReady,

    output logic cacheWe,
    output logic [cacheAddrW-1:0] cacheAddr,
    output logic [dataW-1:0] cacheData,

    output logic loadValid,
    output logic [cacheAddrW-1:0] loadTag,
    output logic [loadW-1:0] loadData,

    output logic fillDone,
    output logic [cacheAddrW-1:0] fillTag
);

    slotTableIf slots ();

    arPayload reqAr;
    logic reqArValid;
    logic reqArReady;
    arPayload axiAr;
    rPayload axiR;
    rPayload bufR;
    logic bufRValid;
    logic bufRTake;

    assign arId = axiAr.id;
    assign arAddr = axiAr.addr;
    assign arLen = axiAr.len;
    assign arSize = axiAr.size;
    assign arBurst = axiAr.burst;

    assign axiR.id = rId;
    assign axiR.data = rData;
    assign axiR.last = rLast;

    transferTable table0 (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqCmd(reqCmd), .reqAddr(reqAddr), .reqTag(reqTag),
        .stall(stall), .fillDone(fillDone), .fillTag(fillTag),
        .slots(slots.slotTable)
    );

    readRequester requester0 (
        .slots(slots.requester),
        .arData(reqAr), .arValid(reqArValid), .arReady(reqArReady)
    );

    streamFifo #(.payloadT(arPayload), .depth(arFifoDepth)) arFifo (
        .clk(clk), .rst(rst),
        .inValid(reqArValid), .inData(reqAr), .inReady(reqArReady),
        .outValid(arValid), .outData(axiAr), .outReady(arReady)
    );

    streamFifo #(.payloadT(rPayload), .depth(rFifoDepth)) rFifo (
        .clk(clk), .rst(rst),
        .inValid(rValid), .inData(axiR), .inReady(rReady),
        .outValid(bufRValid), .outData(bufR), .outReady(bufRTake)
    );

    readDataRouter router0 (
        .clk(clk), .rst(rst),
        .rData(bufR), .rValid(bufRValid), .rTake(bufRTake),
        .slots(slots.router),
        .cacheWe(cacheWe), .cacheAddr(cacheAddr), .cacheData(cacheData),
        .loadValid(loadValid), .loadTag(loadTag), .loadData(loadData)
    );

endmodule

// File: hw/readDataRouter.sv
module readDataRouter import memCtrlPkg::*; (
    input logic clk,
    input logic rst,
    input rPayload rData,
    input logic rValid,
    output logic rTake,
    slotTableIf.router slots,
    output logic cacheWe,
    output logic [cacheAddrW-1:0] cacheAddr,
    output logic [dataW-1:0] cacheData,
    output logic loadValid,
    output logic [cacheAddrW-1:0] loadTag,
    output logic [loadW-1:0] loadData
);

    logic isLoad;
    logic [cacheAddrW-1:0] beatAddr;

    // Cache port and load result never back-pressure
    assign rTake = rValid;
    assign isLoad = slots.slotIsLoad[rData.id];
    assign beatAddr = slots.slotCacheAddr[rData.id] +
        cacheAddrW'(slots.slotBeatIdx[rData.id]);

    // Strobes go out at pop time so the beat count is current for the next beat
    assign slots.beatDone = rValid && !isLoad;
    assign slots.beatSlot = rData.id;
    assign slots.beatLast = rData.last;
    assign slots.loadDone = rValid && isLoad;
    assign slots.loadSlot = rData.id;

    always_ff @(posedge clk) begin
        if (rst) begin
            cacheWe <= 1'b0;
            loadValid <= 1'b0;
        end else begin
            cacheWe <= rValid && !isLoad;
            loadValid <= rValid && isLoad;
        end
    end

    always_ff @(posedge clk) begin
        cacheAddr <= beatAddr;
        cacheData <= rData.data;
        // Load slots keep the client tag in the cache address field
        loadTag <= slots.slotCacheAddr[rData.id];
        loadData <= rData.data[loadW-1:0];
    end

endmodule

// File: hw/readRequester.sv
module readRequester import memCtrlPkg::*; (
    slotTableIf.requester slots,
    output arPayload arData,
    output logic arValid,
    input logic arReady
);

    logic [slotIdW-1:0] pickIdx;
    logic pickOk;

    always_comb begin
        pickIdx = '0;
        pickOk = 1'b0;
        for (int i = 0; i < numSlots; i++) begin
            if (!pickOk && slots.slotValid[i] && slots.slotNeedAr[i]) begin
                pickIdx = slotIdW'(i);
                pickOk = 1'b1;
            end
        end
    end

    always_comb begin
        arData = '0;
        arData.id = pickIdx;
        arData.addr = slots.slotReadAddr[pickIdx];
        if (slots.slotIsLoad[pickIdx]) begin
            arData.len = '0;
            arData.size = sizeWord;
            arData.burst = burstFixed;
        end else begin
            // Whole line as one INCR burst
            arData.len = axiLenW'(beatsPerLine - 1);
            arData.size = sizeBeat;
            arData.burst = burstIncr;
        end
    end

    assign arValid = pickOk;
    assign slots.arIssue = pickOk && arReady;
    assign slots.arSlot = pickIdx;

endmodule

// File: hw/transferTable.sv
module transferTable import memCtrlPkg::*; (
    input logic clk,
    input logic rst,
    input logic [numClients-1:0] reqValid,
    input memCmd reqCmd [numClients],
    input logic [addrW-1:0] reqAddr [numClients],
    input logic [cacheAddrW-1:0] reqTag [numClients],
    output logic [numClients-1:0] stall,
    output logic fillDone,
    output logic [cacheAddrW-1:0] fillTag,
    slotTableIf.slotTable slots
);

    logic [slotIdW-1:0] enqIdx;
    logic enqOk;
    logic [numClients-1:0] collide;
    logic selOk;
    memCmd selCmd;
    logic [addrW-1:0] selAddr;
    logic [cacheAddrW-1:0] selTag;

    // Lowest free slot
    always_comb begin
        enqIdx = '0;
        enqOk = 1'b0;
        for (int i = 0; i < numSlots; i++) begin
            if (!enqOk && !slots.slotValid[i]) begin
                enqIdx = slotIdW'(i);
                enqOk = 1'b1;
            end
        end
    end

    // A fill may not target a line that another fill is still writing
    always_comb begin
        for (int c = 0; c < numClients; c++) begin
            collide[c] = 1'b0;
            for (int i = 0; i < numSlots; i++) begin
                if (reqCmd[c] == cmdFill && slots.slotValid[i] && !slots.slotIsLoad[i] &&
                    slots.slotCacheAddr[i][cacheAddrW-1:beatIdxW] ==
                    reqTag[c][cacheAddrW-1:beatIdxW]) begin
                    collide[c] = 1'b1;
                end
            end
        end
    end

    // Lowest index client without collision wins, all others stall
    always_comb begin
        stall = '1;
        selOk = 1'b0;
        selCmd = cmdNone;
        selAddr = '0;
        selTag = '0;
        for (int c = 0; c < numClients; c++) begin
            if (!selOk && enqOk && reqValid[c] && reqCmd[c] != cmdNone && !collide[c]) begin
                selOk = 1'b1;
                selCmd = reqCmd[c];
                selAddr = reqAddr[c];
                selTag = reqTag[c];
                stall[c] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slots.slotValid <= '0;
            slots.slotNeedAr <= '0;
            fillDone <= 1'b0;
        end else begin
            fillDone <= slots.beatDone && slots.beatLast;
            if (slots.arIssue) begin
                slots.slotNeedAr[slots.arSlot] <= 1'b0;
            end
            if (slots.beatDone && slots.beatLast) begin
                slots.slotValid[slots.beatSlot] <= 1'b0;
            end
            if (slots.loadDone) begin
                slots.slotValid[slots.loadSlot] <= 1'b0;
            end
            if (selOk) begin
                slots.slotValid[enqIdx] <= 1'b1;
                slots.slotNeedAr[enqIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        fillTag <= slots.slotCacheAddr[slots.beatSlot];
        if (slots.beatDone) begin
            slots.slotBeatIdx[slots.beatSlot] <= slots.slotBeatIdx[slots.beatSlot] + 1'b1;
        end
        if (selOk) begin
            slots.slotIsLoad[enqIdx] <= selCmd == cmdLoadWord;
            slots.slotBeatIdx[enqIdx] <= '0;
            if (selCmd == cmdFill) begin
                // Fills start at the line base
                slots.slotReadAddr[enqIdx] <= {selAddr[addrW-1:lineOffW], lineOffW'(0)};
                slots.slotCacheAddr[enqIdx] <= {selTag[cacheAddrW-1:beatIdxW], beatIdxW'(0)};
            end else begin
                slots.slotReadAddr[enqIdx] <= selAddr;
                slots.slotCacheAddr[enqIdx] <= selTag;
            end
        end
    end

endmodule

// File: hw/streamFifo.sv
module streamFifo #(
    parameter type payloadT = logic,
    parameter int depth = 4
) (
    input logic clk,
    input logic rst,
    input logic inValid,
    input payloadT inData,
    output logic inReady,
    output logic outValid,
    output payloadT outData,
    input logic outReady
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    payloadT mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic push;
    logic pop;

    assign inReady = count != cntW'(depth);
    assign outValid = count != '0;
    assign outData = mem[rdPtr];
    assign push = inValid && inReady;
    assign pop = outValid && outReady;

    // Wrap at depth, which need not be a power of two
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

endmodule

// File: hw/slotTableIf.sv
interface slotTableIf import memCtrlPkg::*; ();

    // Slot state, one bit or field per slot
    logic [numSlots-1:0] slotValid;
    logic [numSlots-1:0] slotNeedAr;
    logic [numSlots-1:0] slotIsLoad;
    logic [numSlots-1:0][addrW-1:0] slotReadAddr;
    logic [numSlots-1:0][cacheAddrW-1:0] slotCacheAddr;
    logic [numSlots-1:0][beatIdxW-1:0] slotBeatIdx;

    // AR payload accepted by the AR FIFO
    logic arIssue;
    logic [slotIdW-1:0] arSlot;

    // Read beats consumed by the router
    logic beatDone;
    logic [slotIdW-1:0] beatSlot;
    logic beatLast;
    logic loadDone;
    logic [slotIdW-1:0] loadSlot;

    modport slotTable (
        output slotValid, slotNeedAr, slotIsLoad, slotReadAddr, slotCacheAddr, slotBeatIdx,
        input arIssue, arSlot, beatDone, beatSlot, beatLast, loadDone, loadSlot
    );

    modport requester (
        input slotValid, slotNeedAr, slotIsLoad, slotReadAddr,
        output arIssue, arSlot
    );

    modport router (
        input slotIsLoad, slotCacheAddr, slotBeatIdx,
        output beatDone, beatSlot, beatLast, loadDone, loadSlot
    );

endinterface

// File: hw/memCtrlPkg.sv
package memCtrlPkg;

    // Client and slot counts
    localparam int numClients = 2;
    localparam int numSlots = 4;
    localparam int slotIdW = 2;

    localparam int addrW = 32;
    localparam int dataW = 128;
    localparam int loadW = 32;

    // 64 byte line made of four 16 byte beats
    localparam int beatsPerLine = 4;
    localparam int beatIdxW = 2;
    localparam int lineOffW = 6;
    localparam int cacheAddrW = 8;

    localparam int arFifoDepth = 4;
    localparam int rFifoDepth = 8;

    // AXI read address fields
    localparam int axiLenW = 8;
    localparam int axiSizeW = 3;
    localparam int axiBurstW = 2;
    localparam logic [axiBurstW-1:0] burstFixed = 2'b00;
    localparam logic [axiBurstW-1:0] burstIncr = 2'b01;
    localparam logic [axiSizeW-1:0] sizeWord = 3'd2;
    localparam logic [axiSizeW-1:0] sizeBeat = 3'd4;

    typedef enum logic [1:0] {
        cmdNone,
        cmdFill,
        cmdLoadWord
    } memCmd;

    typedef struct packed {
        logic [slotIdW-1:0] id;
        logic [addrW-1:0] addr;
        logic [axiLenW-1:0] len;
        logic [axiSizeW-1:0] size;
        logic [axiBurstW-1:0] burst;
    } arPayload;

    typedef struct packed {
        logic [slotIdW-1:0] id;
        logic [dataW-1:0] data;
        logic last;
    } rPayload;

endpackage
